// File: rtl/scroll_pkg.sv
/* scroll layer shared definitions
   sizes, CPU scroll registers, tile descriptor and FSM states */
`default_nettype none

package scroll_pkg;

    // memory and buffer sizes
    localparam int map_aw  = 14;   // 3 page + 5 row + 6 column
    localparam int pat_aw  = 17;   // 13 code + 3 fine row + 1 zero
    localparam int pxl_w   = 11;   // 1 prio + 7 palette + 3 colour
    localparam int line_aw = 9;    // 512 columns per half

    // first scan column drawn on a line
    localparam logic [8:0] hscan_start = 9'h68;

    // scroll registers as the CPU writes them
    typedef struct packed {
        logic [15:0] pages;   // four 3-bit page fields, one per quadrant
        logic [8:0]  hscr;
        logic [7:0]  vscr;
    } scroll_regs_t;

    // one tile, fetcher to drawer
    typedef struct packed {
        logic [12:0] code;    // bank bit + 12-bit tile number
        logic [7:0]  attr;    // priority and palette
        logic [2:0]  vfine;   // row inside the tile
        logic [8:0]  hstart;  // buffer column of pixel 0
    } tile_desc_t;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_map_req,
        fetch_map_wait,
        fetch_hand
    } fetch_state_e;

    typedef enum logic [1:0] {
        draw_idle,
        draw_pat_req,
        draw_pat_wait,
        draw_shift
    } draw_state_e;

endpackage

`default_nettype wire

// File: rtl/scroll_map_fetch.sv
/* tile map fetcher
   scrolls the scan position, picks the page per quadrant, reads the map
   entry and hands a tile descriptor to the drawer over req/ack */
`timescale 1ns/1ps
`default_nettype none

module scroll_map_fetch (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              hblank,
    input  wire  [8:0]                       vrender,
    input  wire  scroll_pkg::scroll_regs_t   regs,
    input  wire                              line_done,
    output logic                             map_req,
    output logic [scroll_pkg::map_aw-1:0]    map_addr,
    input  wire                              map_ack,
    input  wire  [15:0]                      map_data,
    output logic                             desc_req,
    output scroll_pkg::tile_desc_t           desc,
    input  wire                              desc_ack
);
    import scroll_pkg::*;

    fetch_state_e st;

    logic       hb_l;        // hblank one clk late
    logic       line_start;
    logic       pend;        // line start waiting for the FSM
    logic       done;        // drawer wrapped, no more tiles this line
    logic [8:0] vscan;       // line latched at line start
    logic [8:0] hscan;       // scan column of the next tile
    logic [8:0] hpos;
    logic [7:0] vpos;
    logic       hov;
    logic       vov;
    logic [2:0] page;
    logic [8:0] hstart;      // hscan pulled back to the tile boundary

    assign line_start = hb_l & ~hblank;   // hblank falling edge

    always_comb begin
        {hov, hpos} = {1'b0, hscan} - {1'b0, regs.hscr};
        {vov, vpos} = vscan + {1'b0, regs.vscr};
        case ({vov, hov})
            2'b10:   page = regs.pages[14:12];   // upper left
            2'b11:   page = regs.pages[10:8];    // upper right
            2'b00:   page = regs.pages[6:4];     // lower left
            default: page = regs.pages[2:0];     // lower right
        endcase
        // only the first tile is unaligned, later ones have hpos[2:0] zero
        hstart = hscan - {6'd0, hpos[2:0]};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= fetch_idle;
            hb_l     <= 1'b0;
            pend     <= 1'b0;
            done     <= 1'b0;
            vscan    <= '0;
            hscan    <= hscan_start;
            map_req  <= 1'b0;
            desc_req <= 1'b0;
        end else begin
            hb_l <= hblank;
            case (st)
                fetch_idle: begin
                    if (pend) begin
                        hscan <= hscan_start;
                        done  <= 1'b0;
                        pend  <= 1'b0;
                        st    <= fetch_map_req;
                    end
                end
                fetch_map_req: begin
                    if (!map_ack) begin   // previous cycle fully closed
                        map_req <= 1'b1;
                        st      <= fetch_map_wait;
                    end
                end
                fetch_map_wait: begin
                    if (map_ack) begin
                        map_req <= 1'b0;
                        st      <= fetch_hand;
                    end
                end
                fetch_hand: begin
                    if (!desc_req) begin
                        if (!desc_ack)
                            desc_req <= 1'b1;
                    end else if (desc_ack) begin
                        desc_req <= 1'b0;
                        hscan    <= desc.hstart + 9'd8;   // next tile boundary
                        st       <= (done || line_done) ? fetch_idle : fetch_map_req;
                    end
                end
                default: st <= fetch_idle;
            endcase
            // line events win over the FSM updates above
            if (line_done)
                done <= 1'b1;
            if (line_start) begin
                vscan <= vrender;
                pend  <= 1'b1;
            end
        end
    end

    // address and descriptor payload, held while req is up
    always_ff @(posedge clk) begin
        if (st == fetch_map_req && !map_ack) begin
            map_addr    <= {page, vpos[7:3], hpos[8:3]};
            desc.vfine  <= vpos[2:0];
            desc.hstart <= hstart;
        end
        if (st == fetch_map_wait && map_ack) begin
            desc.code <= {map_data[13], map_data[11:0]};   // bank + number
            desc.attr <= map_data[12:5];
        end
    end

endmodule

`default_nettype wire

// File: rtl/scroll_tile_draw.sv
/* tile drawer
   takes a descriptor, fetches its pattern word and writes eight pixels,
   one per clk, into the back half of the line buffer */
`timescale 1ns/1ps
`default_nettype none

module scroll_tile_draw (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              desc_req,
    input  wire  scroll_pkg::tile_desc_t     desc,
    output logic                             desc_ack,
    output logic                             pat_req,
    output logic [scroll_pkg::pat_aw-1:0]    pat_addr,
    input  wire                              pat_ack,
    input  wire  [23:0]                      pat_data,
    output logic                             buf_we,
    output logic [scroll_pkg::line_aw-1:0]   buf_addr,
    output logic [scroll_pkg::pxl_w-1:0]     buf_data,
    output logic                             line_done
);
    import scroll_pkg::*;

    draw_state_e st;

    tile_desc_t  cur;      // tile being drawn
    logic [23:0] planes;   // three bit planes, msb is the next pixel
    logic [8:0]  col;      // buffer column
    logic [2:0]  cnt;      // pixel inside the tile

    assign pat_addr = {cur.code, cur.vfine, 1'b0};
    assign buf_we   = (st == draw_shift);
    assign buf_addr = col;
    assign buf_data = {cur.attr, planes[23], planes[15], planes[7]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= draw_idle;
            desc_ack  <= 1'b0;
            pat_req   <= 1'b0;
            line_done <= 1'b0;
            col       <= '0;
            cnt       <= '0;
        end else begin
            line_done <= 1'b0;
            if (desc_ack && !desc_req)
                desc_ack <= 1'b0;   // close the descriptor handshake
            case (st)
                draw_idle: begin
                    if (desc_req && !desc_ack) begin
                        desc_ack <= 1'b1;
                        st       <= draw_pat_req;
                    end
                end
                draw_pat_req: begin
                    if (!pat_ack) begin
                        pat_req <= 1'b1;
                        st      <= draw_pat_wait;
                    end
                end
                draw_pat_wait: begin
                    if (pat_ack) begin
                        pat_req <= 1'b0;
                        col     <= cur.hstart;
                        cnt     <= '0;
                        st      <= draw_shift;
                    end
                end
                draw_shift: begin
                    col <= col + 9'd1;   // wraps freely, writes not gated
                    cnt <= cnt + 3'd1;
                    if (&col)
                        line_done <= 1'b1;   // just wrote column 511
                    if (&cnt)
                        st <= draw_idle;
                end
                default: st <= draw_idle;
            endcase
        end
    end

    // descriptor and pattern payload
    always_ff @(posedge clk) begin
        if (st == draw_idle && desc_req && !desc_ack)
            cur <= desc;
        if (st == draw_pat_wait && pat_ack) begin
            planes <= pat_data;
        end else if (st == draw_shift) begin
            planes[23:16] <= planes[23:16] << 1;
            planes[15:8]  <= planes[15:8] << 1;
            planes[7:0]   <= planes[7:0] << 1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/scroll_line_buf.sv
/* double line buffer
   drawer fills the back half, video reads and erases the front half */
`timescale 1ns/1ps
`default_nettype none

module scroll_line_buf (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              hblank,
    input  wire                              we,
    input  wire  [scroll_pkg::line_aw-1:0]   wr_addr,
    input  wire  [scroll_pkg::pxl_w-1:0]     wr_data,
    input  wire  [scroll_pkg::line_aw-1:0]   rd_addr,
    output logic [scroll_pkg::pxl_w-1:0]     rd_data
);
    import scroll_pkg::*;

    logic [pxl_w-1:0] mem [0:1][0:(1 << line_aw)-1];

    logic sel;    // index of the front half
    logic hb_l;

    // select flips on the hblank falling edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel  <= 1'b0;
            hb_l <= 1'b0;
        end else begin
            hb_l <= hblank;
            if (hb_l && !hblank)
                sel <= ~sel;
        end
    end

    // registered read of the front half
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rd_data <= '0;
        else
            rd_data <= mem[sel][rd_addr];
    end

    always_ff @(posedge clk) begin
        if (we)
            mem[~sel][wr_addr] <= wr_data;   // back half
        mem[sel][rd_addr] <= '0;   // erase behind the read
    end

endmodule

`default_nettype wire

// File: rtl/scroll_layer.sv
/* tilemap scroll layer top
   map fetcher feeds the tile drawer, which fills the line buffer */
`timescale 1ns/1ps
`default_nettype none

module scroll_layer (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              hblank,
    input  wire  [8:0]                       vrender,
    input  wire  [8:0]                       hdump,
    input  wire  scroll_pkg::scroll_regs_t   regs,
    // tile map memory
    output wire                              map_req,
    output wire  [scroll_pkg::map_aw-1:0]    map_addr,
    input  wire                              map_ack,
    input  wire  [15:0]                      map_data,
    // pattern memory
    output wire                              pat_req,
    output wire  [scroll_pkg::pat_aw-1:0]    pat_addr,
    input  wire                              pat_ack,
    input  wire  [23:0]                      pat_data,
    // video
    output wire  [scroll_pkg::pxl_w-1:0]     pxl
);
    import scroll_pkg::*;

    wire                 desc_req;
    wire                 desc_ack;
    tile_desc_t          desc;
    wire                 line_done;   // drawer wrapped past 511
    wire                 buf_we;
    wire [line_aw-1:0]   buf_addr;
    wire [pxl_w-1:0]     buf_data;

    scroll_map_fetch fetch_i (
        .clk       (clk),
        .rst       (rst),
        .hblank    (hblank),
        .vrender   (vrender),
        .regs      (regs),
        .line_done (line_done),
        .map_req   (map_req),
        .map_addr  (map_addr),
        .map_ack   (map_ack),
        .map_data  (map_data),
        .desc_req  (desc_req),
        .desc      (desc),
        .desc_ack  (desc_ack)
    );

    scroll_tile_draw draw_i (
        .clk       (clk),
        .rst       (rst),
        .desc_req  (desc_req),
        .desc      (desc),
        .desc_ack  (desc_ack),
        .pat_req   (pat_req),
        .pat_addr  (pat_addr),
        .pat_ack   (pat_ack),
        .pat_data  (pat_data),
        .buf_we    (buf_we),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data),
        .line_done (line_done)
    );

    scroll_line_buf line_buf_i (
        .clk     (clk),
        .rst     (rst),
        .hblank  (hblank),
        .we      (buf_we),
        .wr_addr (buf_addr),
        .wr_data (buf_data),
        .rd_addr (hdump),
        .rd_data (pxl)
    );

endmodule

`default_nettype wire

// File: testbench/tb_scroll_mem.sv
/* map and pattern memory models for the scroll layer
   four-phase responders, content is a fixed mix of the address bits */
`timescale 1ns/1ps
`default_nettype none

module tb_scroll_mem (
    input  wire         clk,
    input  wire         rand_delay,   // ack after 0..5 clks when set
    input  wire         map_req,
    input  wire  [13:0] map_addr,
    output logic        map_ack,
    output logic [15:0] map_data,
    input  wire         pat_req,
    input  wire  [16:0] pat_addr,
    output logic        pat_ack,
    output logic [23:0] pat_data
);

    function automatic logic [15:0] map_word(input logic [13:0] a);
        return {a[1:0], a[13:0]} ^ {a[6:0], a[13:5]};
    endfunction

    function automatic logic [23:0] pat_word(input logic [16:0] a);
        return {a[16:0], a[6:0]} ^ {a[7:0], a[16:1]} ^ 24'h5a3c96;
    endfunction

    function automatic int ack_delay();
        return rand_delay ? $urandom_range(5, 0) : 0;
    endfunction

    // seeded parent, both port responders forked from it
    initial begin
        void'($urandom(13));
        map_ack  = 1'b0;
        map_data = '0;
        pat_ack  = 1'b0;
        pat_data = '0;
        fork
            forever begin   // map port
                @(posedge clk);
                #1;
                if (map_req && !map_ack) begin
                    repeat (ack_delay()) begin
                        @(posedge clk);
                        #1;
                    end
                    map_data = map_word(map_addr);
                    map_ack  = 1'b1;
                    for (int n = 0; map_req && n < 64; n++) begin   // wait for req low
                        @(posedge clk);
                        #1;
                    end
                    map_ack = 1'b0;
                end
            end
            forever begin   // pattern port, same handshake
                @(posedge clk);
                #1;
                if (pat_req && !pat_ack) begin
                    repeat (ack_delay()) begin
                        @(posedge clk);
                        #1;
                    end
                    pat_data = pat_word(pat_addr);
                    pat_ack  = 1'b1;
                    for (int n = 0; pat_req && n < 64; n++) begin
                        @(posedge clk);
                        #1;
                    end
                    pat_ack = 1'b0;
                end
            end
        join
    end

endmodule

`default_nettype wire

// File: testbench/scroll_layer_asserts.sv
/* protocol checks bound into the scroll layer
   four-phase req/ack on both memories and the descriptor link, reset state */
`timescale 1ns/1ps
`default_nettype none

module scroll_layer_asserts (
    input wire                              clk,
    input wire                              rst,
    input wire                              map_req,
    input wire [scroll_pkg::map_aw-1:0]     map_addr,
    input wire                              map_ack,
    input wire                              pat_req,
    input wire [scroll_pkg::pat_aw-1:0]     pat_addr,
    input wire                              pat_ack,
    input wire                              desc_req,
    input wire scroll_pkg::tile_desc_t      desc,
    input wire                              desc_ack,
    input wire                              buf_we,
    input wire                              line_done,
    input wire [scroll_pkg::pxl_w-1:0]      pxl
);

    int fail_count = 0;   // failed assertions so far

    // req and address held until ack
    map_hold: assert property (@(posedge clk) disable iff (rst)
        map_req && !map_ack |=> map_req && $stable(map_addr))
        else begin
            fail_count++;
            $error("map_req or map_addr changed before map_ack");
        end

    pat_hold: assert property (@(posedge clk) disable iff (rst)
        pat_req && !pat_ack |=> pat_req && $stable(pat_addr))
        else begin
            fail_count++;
            $error("pat_req or pat_addr changed before pat_ack");
        end

    desc_hold: assert property (@(posedge clk) disable iff (rst)
        desc_req && !desc_ack |=> desc_req && $stable(desc))
        else begin
            fail_count++;
            $error("desc_req or desc changed before desc_ack");
        end

    // new req only once the last ack is gone
    map_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(map_req) |-> !$past(map_ack))
        else begin
            fail_count++;
            $error("map_req rose while map_ack was still high");
        end

    pat_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(pat_req) |-> !$past(pat_ack))
        else begin
            fail_count++;
            $error("pat_req rose while pat_ack was still high");
        end

    reset_quiet: assert property (@(posedge clk)
        rst |-> !map_req && !pat_req && !desc_req && !desc_ack && !buf_we
                && !line_done && pxl == '0)
        else begin
            fail_count++;
            $error("outputs not quiet during reset");
        end

endmodule

bind scroll_layer scroll_layer_asserts asserts_i (.*);

`default_nettype wire

// File: testbench/tb_scroll_layer.sv
/* scroll layer testbench
   renders lines under several scroll settings and checks every active
   pixel against a reference built from the map and pattern content */
`timescale 1ns/1ps
`default_nettype none

module tb_scroll_layer;
    import scroll_pkg::*;

    localparam int drawn_limit = 8000;   // clks allowed for one line

    logic         clk = 1'b0;
    logic         rst;
    logic         hblank;
    logic [8:0]   vrender;
    logic [8:0]   hdump;
    scroll_regs_t regs;
    logic         rand_delay;
    wire          map_req;
    wire  [13:0]  map_addr;
    wire          map_ack;
    wire  [15:0]  map_data;
    wire          pat_req;
    wire  [16:0]  pat_addr;
    wire          pat_ack;
    wire  [23:0]  pat_data;
    wire  [10:0]  pxl;

    string cur_name;
    int    test_errs;
    int    errors;
    int    tests_run;
    int    tests_bad;
    bit    stalled;     // a wait ran out, rest of the run skipped

    always #10 clk = ~clk;

    scroll_layer scroll_layer_i (
        .clk      (clk),
        .rst      (rst),
        .hblank   (hblank),
        .vrender  (vrender),
        .hdump    (hdump),
        .regs     (regs),
        .map_req  (map_req),
        .map_addr (map_addr),
        .map_ack  (map_ack),
        .map_data (map_data),
        .pat_req  (pat_req),
        .pat_addr (pat_addr),
        .pat_ack  (pat_ack),
        .pat_data (pat_data),
        .pxl      (pxl)
    );

    tb_scroll_mem mem_i (
        .clk        (clk),
        .rand_delay (rand_delay),
        .map_req    (map_req),
        .map_addr   (map_addr),
        .map_ack    (map_ack),
        .map_data   (map_data),
        .pat_req    (pat_req),
        .pat_addr   (pat_addr),
        .pat_ack    (pat_ack),
        .pat_data   (pat_data)
    );

    // expected pixel at buffer column c for line v
    function automatic logic [10:0] reference_pixel(input logic [8:0] v,
                                                    input scroll_regs_t r,
                                                    input logic [8:0] c);
        logic [8:0]  x;        // scrolled column
        logic [8:0]  tstart;   // first column of the tile holding c
        logic [8:0]  scan;
        logic        hov;
        logic [8:0]  vs;
        logic [2:0]  page;
        logic [15:0] entry;
        logic [23:0] pat;
        logic [2:0]  p;
        x      = c - r.hscr;
        tstart = c - {6'd0, x[2:0]};
        scan   = (tstart < hscan_start) ? hscan_start : tstart;   // first tile scans at start
        hov    = scan < r.hscr;
        vs     = v + {1'b0, r.vscr};
        case ({vs[8], hov})
            2'b10:   page = r.pages[14:12];
            2'b11:   page = r.pages[10:8];
            2'b00:   page = r.pages[6:4];
            default: page = r.pages[2:0];
        endcase
        entry = mem_i.map_word({page, vs[7:3], x[8:3]});
        pat   = mem_i.pat_word({entry[13], entry[11:0], vs[2:0], 1'b0});
        p     = x[2:0];
        return {entry[12:5], pat[23 - p], pat[15 - p], pat[7 - p]};
    endfunction

    task automatic check_value(input string name, input logic [23:0] exp,
                               input logic [23:0] act);
        assert (act === exp) else begin
            $display("Fail %s expected %0h actual %0h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_name  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        $display("%s done, %0d checks failed", cur_name, test_errs);
        tests_run++;
        if (test_errs != 0)
            tests_bad++;
        errors += test_errs;
    endtask

    // hblank high for two clks, then the falling edge
    task automatic line_start();
        hblank = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        hblank = 1'b0;
    endtask

    // line_done, then fetcher and drawer both idle again
    task automatic wait_line_drawn(input bit fine_check);
        logic [8:0] vs;
        bit         seen;
        bit         finished;
        int         n;
        if (stalled)
            return;
        vs       = vrender + {1'b0, regs.vscr};
        seen     = 1'b0;
        finished = 1'b0;
        for (n = 0; !finished && n < drawn_limit; n++) begin
            @(posedge clk);
            #1;
            seen = seen | scroll_layer_i.line_done;
            if (fine_check && pat_req)
                check_value(cur_name, vs[2:0], pat_addr[3:1]);   // fine row
            finished = seen && scroll_layer_i.fetch_i.st == fetch_idle
                            && scroll_layer_i.draw_i.st == draw_idle;
        end
        if (!finished) begin
            $display("timeout in %s: the drawer never finished the line", cur_name);
            stalled = 1'b1;
        end
    endtask

    // hdump over the active columns, pxl one clk later
    task automatic sweep_line(input bit erased);
        logic [10:0] exp;
        if (stalled)
            return;
        for (int c = 'h70; c <= 512; c++) begin
            @(posedge clk);
            #1;
            if (c > 'h70) begin
                exp = erased ? 11'd0 : reference_pixel(vrender, regs, c[8:0] - 9'd1);
                check_value(cur_name, exp, pxl);
            end
            hdump = c[8:0];   // parks at 0 after the last column
        end
    endtask

    task automatic render_line(input logic [8:0] v, input scroll_regs_t r,
                               input bit twice, input bit fine_check);
        if (stalled)
            return;
        @(posedge clk);
        #1;
        vrender = v;
        regs    = r;
        line_start();                  // draw into the back half
        wait_line_drawn(fine_check);
        line_start();                  // swap, next line drawn meanwhile
        sweep_line(1'b0);
        wait_line_drawn(fine_check);
        if (twice)
            sweep_line(1'b1);          // erased by the first read
    endtask

    initial begin
        rst        = 1'b0;
        hblank     = 1'b1;
        vrender    = '0;
        hdump      = '0;
        regs       = '0;
        rand_delay = 1'b0;
        stalled    = 1'b0;
        errors     = 0;
        tests_run  = 0;
        tests_bad  = 0;
        #1;
        rst = 1'b1;   // async reset edge ahead of the first clk edge

        start_test("reset_state");
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #1;
            check_value(cur_name, 24'd0, pxl);
            check_value(cur_name, 24'd0, {map_req, pat_req});
            hdump = 9'h070 + 9'h55 * i[8:0];
        end
        rst   = 1'b0;
        hdump = '0;
        repeat (8) begin   // no line start yet, memories untouched
            @(posedge clk);
            #1;
            check_value(cur_name, 24'd0, {map_req, pat_req});
        end
        finish_test();

        start_test("zero_scroll");
        render_line(9'h010, {16'h0000, 9'h000, 8'h00}, 1'b0, 1'b0);
        render_line(9'h09b, {16'h0000, 9'h000, 8'h00}, 1'b0, 1'b0);
        finish_test();

        start_test("hscroll_page");   // hov clears at scan 0x120
        render_line(9'h030, {16'h1234, 9'h120, 8'h00}, 1'b0, 1'b0);
        finish_test();

        start_test("vscroll_page");   // 0x40 + 0xd3 sets vov
        render_line(9'h040, {16'h1234, 9'h000, 8'hd3}, 1'b0, 1'b1);
        finish_test();

        start_test("random_ack");
        rand_delay = 1'b1;
        render_line(9'h022, {16'h5670, 9'h0b5, 8'h37}, 1'b0, 1'b0);
        finish_test();

        start_test("erase_on_read");
        render_line(9'h055, {16'h1234, 9'h1f3, 8'h80}, 1'b1, 1'b0);
        finish_test();

        $display("%0d tests, %0d with errors, %0d checks failed, %0d assertion failures",
                 tests_run, tests_bad, errors, scroll_layer_i.asserts_i.fail_count);
        if (errors == 0 && !stalled && scroll_layer_i.asserts_i.fail_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/scroll_pkg.sv
rtl/scroll_map_fetch.sv
rtl/scroll_tile_draw.sv
rtl/scroll_line_buf.sv
rtl/scroll_layer.sv
testbench/tb_scroll_mem.sv
testbench/scroll_layer_asserts.sv
testbench/tb_scroll_layer.sv
